/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_top -o tb_top_sim

./obj_dir/tb_top_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
grep -q "Regression passed" sim.log

/* sim.f */
src/cpu_pkg.sv
src/regfile.sv
src/alu.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/cpu_top.sv
testbench/cpu_sva.sv
testbench/cpu_checker.sv
testbench/tb_top.sv

/* src/alu.sv */
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   src1,
    input  cpu_pkg::word_t   src2,
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            // lu12i immediate arrives already shifted
            ALU_LUI:  result = src2;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_LUI
    } alu_op_t;

    // major opcode, inst[31:26]
    localparam logic [5:0] OP6_ALU   = 6'h00;
    localparam logic [5:0] OP6_LU12I = 6'h05;
    localparam logic [5:0] OP6_MEM   = 6'h0a;
    localparam logic [5:0] OP6_B     = 6'h14;
    localparam logic [5:0] OP6_BL    = 6'h15;
    localparam logic [5:0] OP6_BEQ   = 6'h16;
    localparam logic [5:0] OP6_BNE   = 6'h17;

    // inst[25:22]
    localparam logic [3:0] OP4_ADDI = 4'ha;
    localparam logic [3:0] OP4_LDW  = 4'h2;
    localparam logic [3:0] OP4_STW  = 4'h6;

    // inst[21:20] and inst[19:15] of the 3R group
    localparam logic [1:0] OP2_3R   = 2'h1;
    localparam logic [4:0] OP5_ADD  = 5'h00;
    localparam logic [4:0] OP5_SUB  = 5'h02;
    localparam logic [4:0] OP5_SLT  = 5'h04;
    localparam logic [4:0] OP5_SLTU = 5'h05;
    localparam logic [4:0] OP5_NOR  = 5'h08;
    localparam logic [4:0] OP5_AND  = 5'h09;
    localparam logic [4:0] OP5_OR   = 5'h0a;
    localparam logic [4:0] OP5_XOR  = 5'h0b;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     value;
    } fwd_t;

    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     src1;
        word_t     src2;
        word_t     store_data;
        reg_addr_t dest;
        logic      reg_write;
        logic      is_load;
        logic      is_store;
    } id_ex_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        reg_addr_t dest;
        logic      reg_write;
        logic      is_load;
    } ex_mem_t;

    typedef struct packed {
        logic  en;
        logic  we;
        word_t addr;
        word_t wdata;
    } data_req_t;

    typedef struct packed {
        logic      we;
        word_t     pc;
        reg_addr_t wnum;
        word_t     wdata;
    } trace_t;

endpackage

`default_nettype wire

/* src/cpu_top.sv */
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c000000
) (
    input  logic               clk,
    input  logic               reset,
    output cpu_pkg::word_t     inst_addr,
    input  cpu_pkg::word_t     inst_rdata,
    output cpu_pkg::data_req_t data_req,
    input  cpu_pkg::word_t     data_rdata,
    output cpu_pkg::trace_t    trace
);
    import cpu_pkg::*;

    logic      id_allow_in;
    logic      redirect_en;
    word_t     redirect_pc;
    word_t     inst;
    word_t     inst_pc;
    logic      inst_valid;
    reg_addr_t rf_raddr1, rf_raddr2, rf_waddr;
    word_t     rf_rdata1, rf_rdata2, rf_wdata;
    logic      rf_we;
    fwd_t      fwd_ex, fwd_mem, fwd_wb;
    logic      ex_is_load;
    reg_addr_t ex_dest;
    id_ex_t    id_ex;
    logic      id_ex_valid;
    ex_mem_t   ex_mem;
    logic      ex_mem_valid;

    // only decode can stall, so only fetch sees allow-in
    fetch_stage #(.RESET_PC(RESET_PC)) fetch0 (
        .clk, .reset, .id_allow_in, .redirect_en, .redirect_pc,
        .inst_rdata, .inst_addr, .inst, .inst_pc, .inst_valid
    );

    decode_stage decode0 (
        .inst, .inst_pc, .inst_valid, .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .fwd_ex, .fwd_mem, .fwd_wb, .ex_is_load, .ex_dest, .redirect_en, .redirect_pc,
        .id_allow_in, .id_ex, .id_ex_valid
    );

    regfile regfile0 (
        .clk, .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rdata1(rf_rdata1),
        .rdata2(rf_rdata2), .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    execute_stage execute0 (
        .clk, .reset, .id_ex, .id_ex_valid, .data_req, .ex_mem, .ex_mem_valid,
        .fwd_ex, .ex_is_load, .ex_dest
    );

    mem_wb_stage mem_wb0 (
        .clk, .reset, .ex_mem, .ex_mem_valid, .data_rdata, .fwd_mem, .fwd_wb,
        .rf_we, .rf_waddr, .rf_wdata, .trace
    );

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  cpu_pkg::word_t     inst,
    input  cpu_pkg::word_t     inst_pc,
    input  logic               inst_valid,
    output cpu_pkg::reg_addr_t rf_raddr1,
    output cpu_pkg::reg_addr_t rf_raddr2,
    input  cpu_pkg::word_t     rf_rdata1,
    input  cpu_pkg::word_t     rf_rdata2,
    input  cpu_pkg::fwd_t      fwd_ex,
    input  cpu_pkg::fwd_t      fwd_mem,
    input  cpu_pkg::fwd_t      fwd_wb,
    input  logic               ex_is_load,
    input  cpu_pkg::reg_addr_t ex_dest,
    output logic               redirect_en,
    output cpu_pkg::word_t     redirect_pc,
    output logic               id_allow_in,
    output cpu_pkg::id_ex_t    id_ex,
    output logic               id_ex_valid
);
    import cpu_pkg::*;

    logic [5:0] op6;
    logic [3:0] op4;
    logic       is_3r;
    logic       inst_add, inst_sub, inst_slt, inst_sltu;
    logic       inst_and, inst_or, inst_xor, inst_nor;
    logic       inst_addi, inst_lu12i, inst_ldw, inst_stw;
    logic       inst_b, inst_bl, inst_beq, inst_bne;
    logic       use_r1, use_r2, load_use, ready_go, taken;
    reg_addr_t  rd;
    word_t      r1_val, r2_val, si12, br_offs;

    // nearest producer wins, r0 never forwarded
    function automatic word_t fwd_pick(input reg_addr_t addr, input word_t rf_val,
                                       input fwd_t ex, input fwd_t mem, input fwd_t wb);
        word_t val;
        val = rf_val;
        if (addr != '0) begin
            if (wb.valid && wb.dest == addr) val = wb.value;
            if (mem.valid && mem.dest == addr) val = mem.value;
            if (ex.valid && ex.dest == addr) val = ex.value;
        end
        return val;
    endfunction

    assign op6   = inst[31:26];
    assign op4   = inst[25:22];
    assign rd    = inst[4:0];
    assign is_3r = (op6 == OP6_ALU) && (op4 == 4'h0) && (inst[21:20] == OP2_3R);

    assign inst_add   = is_3r && inst[19:15] == OP5_ADD;
    assign inst_sub   = is_3r && inst[19:15] == OP5_SUB;
    assign inst_slt   = is_3r && inst[19:15] == OP5_SLT;
    assign inst_sltu  = is_3r && inst[19:15] == OP5_SLTU;
    assign inst_and   = is_3r && inst[19:15] == OP5_AND;
    assign inst_or    = is_3r && inst[19:15] == OP5_OR;
    assign inst_xor   = is_3r && inst[19:15] == OP5_XOR;
    assign inst_nor   = is_3r && inst[19:15] == OP5_NOR;
    assign inst_addi  = (op6 == OP6_ALU) && (op4 == OP4_ADDI);
    assign inst_lu12i = (op6 == OP6_LU12I) && !inst[25];
    assign inst_ldw   = (op6 == OP6_MEM) && (op4 == OP4_LDW);
    assign inst_stw   = (op6 == OP6_MEM) && (op4 == OP4_STW);
    assign inst_b     = op6 == OP6_B;
    assign inst_bl    = op6 == OP6_BL;
    assign inst_beq   = op6 == OP6_BEQ;
    assign inst_bne   = op6 == OP6_BNE;

    // branches and stores read rd as second source
    assign rf_raddr1 = inst[9:5];
    assign rf_raddr2 = (inst_beq || inst_bne || inst_stw) ? rd : inst[14:10];

    assign r1_val = fwd_pick(rf_raddr1, rf_rdata1, fwd_ex, fwd_mem, fwd_wb);
    assign r2_val = fwd_pick(rf_raddr2, rf_rdata2, fwd_ex, fwd_mem, fwd_wb);

    assign use_r1 = is_3r || inst_addi || inst_ldw || inst_stw || inst_beq || inst_bne;
    assign use_r2 = is_3r || inst_stw || inst_beq || inst_bne;

    assign load_use = ex_is_load && ((use_r1 && rf_raddr1 == ex_dest) ||
                                     (use_r2 && rf_raddr2 == ex_dest));
    assign ready_go    = !(inst_valid && load_use);
    assign id_allow_in = ready_go;
    assign id_ex_valid = inst_valid && ready_go;

    assign si12    = {{20{inst[21]}}, inst[21:10]};
    assign br_offs = (inst_b || inst_bl) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}
                                         : {{14{inst[25]}}, inst[25:10], 2'b00};

    assign taken = inst_b || inst_bl || (inst_beq && r1_val == r2_val) ||
                   (inst_bne && r1_val != r2_val);
    assign redirect_en = inst_valid && ready_go && taken;
    assign redirect_pc = inst_pc + br_offs;

    always_comb begin
        id_ex.alu_op = ALU_ADD;
        if (inst_sub) id_ex.alu_op = ALU_SUB;
        if (inst_slt) id_ex.alu_op = ALU_SLT;
        if (inst_sltu) id_ex.alu_op = ALU_SLTU;
        if (inst_and) id_ex.alu_op = ALU_AND;
        if (inst_or) id_ex.alu_op = ALU_OR;
        if (inst_xor) id_ex.alu_op = ALU_XOR;
        if (inst_nor) id_ex.alu_op = ALU_NOR;
        if (inst_lu12i) id_ex.alu_op = ALU_LUI;

        id_ex.pc   = inst_pc;
        // bl computes pc + 4 through the adder
        id_ex.src1 = inst_bl ? inst_pc : r1_val;
        if (inst_bl) begin
            id_ex.src2 = 32'd4;
        end else if (inst_addi || inst_ldw || inst_stw) begin
            id_ex.src2 = si12;
        end else if (inst_lu12i) begin
            id_ex.src2 = {inst[24:5], 12'b0};
        end else begin
            id_ex.src2 = r2_val;
        end
        id_ex.store_data = r2_val;
        id_ex.dest       = inst_bl ? 5'd1 : rd;
        id_ex.reg_write  = inst_add || inst_sub || inst_slt || inst_sltu || inst_and ||
                           inst_or || inst_xor || inst_nor || inst_addi || inst_lu12i ||
                           inst_ldw || inst_bl;
        id_ex.is_load    = inst_ldw;
        id_ex.is_store   = inst_stw;
    end

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::id_ex_t    id_ex,
    input  logic               id_ex_valid,
    output cpu_pkg::data_req_t data_req,
    output cpu_pkg::ex_mem_t   ex_mem,
    output logic               ex_mem_valid,
    output cpu_pkg::fwd_t      fwd_ex,
    output logic               ex_is_load,
    output cpu_pkg::reg_addr_t ex_dest
);
    import cpu_pkg::*;

    id_ex_t ex_r;
    logic   ex_valid;
    word_t  alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_r <= id_ex;
    end

    alu alu0 (
        .op     (ex_r.alu_op),
        .src1   (ex_r.src1),
        .src2   (ex_r.src2),
        .result (alu_result)
    );

    always_comb begin
        data_req.en    = ex_valid && (ex_r.is_load || ex_r.is_store);
        data_req.we    = ex_valid && ex_r.is_store;
        data_req.addr  = {alu_result[XLEN-1:2], 2'b00};
        data_req.wdata = ex_r.store_data;

        ex_mem.pc        = ex_r.pc;
        ex_mem.result    = alu_result;
        ex_mem.dest      = ex_r.dest;
        ex_mem.reg_write = ex_r.reg_write;
        ex_mem.is_load   = ex_r.is_load;

        // load data not here yet, decode stalls instead
        fwd_ex.valid = ex_valid && ex_r.reg_write && !ex_r.is_load;
        fwd_ex.dest  = ex_r.dest;
        fwd_ex.value = alu_result;
    end

    assign ex_mem_valid = ex_valid;
    assign ex_is_load   = ex_valid && ex_r.is_load;
    assign ex_dest      = ex_r.dest;

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
`default_nettype none

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c000000
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           id_allow_in,
    input  logic           redirect_en,
    input  cpu_pkg::word_t redirect_pc,
    input  cpu_pkg::word_t inst_rdata,
    output cpu_pkg::word_t inst_addr,
    output cpu_pkg::word_t inst,
    output cpu_pkg::word_t inst_pc,
    output logic           inst_valid
);
    import cpu_pkg::*;

    word_t pc;
    word_t hold_inst;
    logic  use_hold;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= RESET_PC;
            inst_valid <= 1'b0;
            use_hold   <= 1'b0;
        end else begin
            use_hold <= ~id_allow_in;
            if (id_allow_in) begin
                pc <= redirect_en ? redirect_pc : pc + 32'd4;
                // word arriving next is wrong path after a redirect
                inst_valid <= ~redirect_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (id_allow_in) begin
            inst_pc <= pc;
        end
        // ram output moves on while decode holds
        if (!id_allow_in) begin
            hold_inst <= inst;
        end
    end

    assign inst_addr = pc;
    assign inst      = use_hold ? hold_inst : inst_rdata;

endmodule

`default_nettype wire

/* src/mem_wb_stage.sv */
`default_nettype none

module mem_wb_stage (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::ex_mem_t   ex_mem,
    input  logic               ex_mem_valid,
    input  cpu_pkg::word_t     data_rdata,
    output cpu_pkg::fwd_t      fwd_mem,
    output cpu_pkg::fwd_t      fwd_wb,
    output logic               rf_we,
    output cpu_pkg::reg_addr_t rf_waddr,
    output cpu_pkg::word_t     rf_wdata,
    output cpu_pkg::trace_t    trace
);
    import cpu_pkg::*;

    ex_mem_t   mem_r;
    logic      mem_valid;
    word_t     mem_result;
    logic      wb_we;
    word_t     wb_pc;
    reg_addr_t wb_dest;
    word_t     wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
            wb_we     <= 1'b0;
        end else begin
            mem_valid <= ex_mem_valid;
            wb_we     <= mem_valid && mem_r.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_r   <= ex_mem;
        wb_pc   <= mem_r.pc;
        wb_dest <= mem_r.dest;
        wb_data <= mem_result;
    end

    // ram returns load data during the memory cycle
    assign mem_result = mem_r.is_load ? data_rdata : mem_r.result;

    always_comb begin
        fwd_mem.valid = mem_valid && mem_r.reg_write;
        fwd_mem.dest  = mem_r.dest;
        fwd_mem.value = mem_result;

        fwd_wb.valid = wb_we;
        fwd_wb.dest  = wb_dest;
        fwd_wb.value = wb_data;

        trace.we    = wb_we;
        trace.pc    = wb_pc;
        trace.wnum  = wb_dest;
        trace.wdata = wb_data;
    end

    assign rf_we    = wb_we;
    assign rf_waddr = wb_dest;
    assign rf_wdata = wb_data;

endmodule

`default_nettype wire

/* src/regfile.sv */
`default_nettype none

module regfile (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);
    import cpu_pkg::*;

    word_t regs [0:(1 << REG_ADDR_W) - 1];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* testbench/cpu_checker.sv */
`default_nettype none

module cpu_checker #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c000000
) (
    input  logic            clk,
    input  logic            reset,
    input  cpu_pkg::trace_t trace,
    input  cpu_pkg::word_t  program_mem [0:199],
    input  cpu_pkg::word_t  data_init [0:63],
    input  logic            model_start,
    output int              expected_total,
    output int              consumed,
    output int              mismatch_count,
    output int              extra_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    trace_t expected_q[$];
    int     total_r = 0;
    int     consumed_r = 0;
    int     mismatch_r = 0;
    int     extra_r = 0;

    task automatic run_model();
        word_t     regs [0:31];
        word_t     dmem [0:63];
        word_t     pc, npc, ins, a, b, d, res, addr, idx, si12, off;
        reg_addr_t dst;
        logic      wr, done;
        int        steps;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < 64; i++) dmem[i] = data_init[i];
        pc = RESET_PC;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            idx = (pc - RESET_PC) >> 2;
            if (idx >= 200) begin
                break;
            end
            ins  = program_mem[idx];
            a    = regs[ins[9:5]];
            b    = regs[ins[14:10]];
            d    = regs[ins[4:0]];
            si12 = {{20{ins[21]}}, ins[21:10]};
            dst  = ins[4:0];
            wr   = 1'b0;
            res  = '0;
            npc  = pc + 32'd4;
            case (ins[31:26])
                OP6_ALU: begin
                    if (ins[25:22] == OP4_ADDI) begin
                        res = a + si12;
                        wr  = 1'b1;
                    end else if (ins[25:22] == 4'h0 && ins[21:20] == OP2_3R) begin
                        wr = 1'b1;
                        case (ins[19:15])
                            OP5_ADD:  res = a + b;
                            OP5_SUB:  res = a - b;
                            OP5_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            OP5_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                            OP5_AND:  res = a & b;
                            OP5_OR:   res = a | b;
                            OP5_XOR:  res = a ^ b;
                            OP5_NOR:  res = ~(a | b);
                            default:  wr = 1'b0;
                        endcase
                    end
                end
                OP6_LU12I: begin
                    res = {ins[24:5], 12'b0};
                    wr  = !ins[25];
                end
                OP6_MEM: begin
                    addr = a + si12;
                    if (ins[25:22] == OP4_LDW) begin
                        res = dmem[addr[7:2]];
                        wr  = 1'b1;
                    end else if (ins[25:22] == OP4_STW) begin
                        dmem[addr[7:2]] = d;
                    end
                end
                OP6_B, OP6_BL: begin
                    off = {{4{ins[9]}}, ins[9:0], ins[25:10], 2'b00};
                    npc = pc + off;
                    if (ins[31:26] == OP6_BL) begin
                        res = pc + 32'd4;
                        dst = 5'd1;
                        wr  = 1'b1;
                    end else if (off == '0) begin
                        // self loop ends the program
                        done = 1'b1;
                    end
                end
                OP6_BEQ, OP6_BNE: begin
                    off = {{14{ins[25]}}, ins[25:10], 2'b00};
                    if ((ins[31:26] == OP6_BEQ) == (a == d)) npc = pc + off;
                end
                default: ;
            endcase
            if (wr) begin
                expected_q.push_back({1'b1, pc, dst, res});
                if (dst != '0) regs[dst] = res;
            end
            pc = npc;
            steps++;
        end
        if (!done) begin
            $display("model stopped before the final self branch at pc %h", pc);
            mismatch_r++;
        end
        total_r = expected_q.size();
    endtask

    task automatic compare_field(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            mismatch_r++;
        end
    endtask

    always @(posedge model_start) begin
        run_model();
    end

    // trace comes from flops and settles before the falling edge
    always @(negedge clk) begin
        trace_t exp;
        if (!reset && trace.we) begin
            if (expected_q.size() == 0) begin
                $display("unexpected trace write from pc %h after the last expected record",
                         trace.pc);
                extra_r++;
            end else begin
                exp = expected_q.pop_front();
                consumed_r++;
                compare_field("trace pc", exp.pc, trace.pc);
                compare_field("trace wnum", word_t'(exp.wnum), word_t'(trace.wnum));
                compare_field("trace wdata", exp.wdata, trace.wdata);
            end
        end
    end

    assign expected_total = total_r;
    assign consumed       = consumed_r;
    assign mismatch_count = mismatch_r;
    assign extra_count    = extra_r;

endmodule

`default_nettype wire

/* testbench/cpu_sva.sv */
`default_nettype none

module cpu_sva (
    input logic               clk,
    input logic               reset,
    input cpu_pkg::word_t     inst_addr,
    input cpu_pkg::data_req_t data_req,
    input cpu_pkg::trace_t    trace
);
    timeunit 1ns;
    timeprecision 1ps;

    // pipeline comes out of reset empty
    assert property (@(posedge clk) reset |=> (!data_req.en && !trace.we))
        else $error("data request or trace write right after reset");

    assert property (@(posedge clk) disable iff (reset) data_req.we |-> data_req.en)
        else $error("data write enable without request enable");

    assert property (@(posedge clk) disable iff (reset) inst_addr[1:0] == 2'b00)
        else $error("instruction address not word aligned");

    assert property (@(posedge clk) disable iff (reset)
                     data_req.en |-> data_req.addr[1:0] == 2'b00)
        else $error("data address not word aligned");

endmodule

bind cpu_top cpu_sva sva0 (
    .clk      (clk),
    .reset    (reset),
    .inst_addr(inst_addr),
    .data_req (data_req),
    .trace    (trace)
);

`default_nettype wire

/* testbench/tb_top.sv */
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam word_t RESET_PC = 32'h1c000000;
    localparam int    PROG_LEN = 200;

    logic        clk;
    logic        reset;
    word_t       inst_addr, inst_rdata, data_rdata;
    data_req_t   data_req;
    trace_t      trace;
    word_t       imem [0:PROG_LEN-1];
    word_t       dmem [0:63];
    word_t       dmem_init [0:63];
    word_t       imem_addr_q, dmem_addr_q;
    logic [31:0] lfsr_state;
    logic        model_start;
    int          expected_total, consumed, mismatch_count, extra_count;
    int          tb_errors, cycles;

    cpu_top #(.RESET_PC(RESET_PC)) dut0 (
        .clk, .reset, .inst_addr, .inst_rdata, .data_req, .data_rdata, .trace
    );

    cpu_checker #(.RESET_PC(RESET_PC)) checker0 (
        .clk, .reset, .trace, .program_mem(imem), .data_init(dmem_init), .model_start,
        .expected_total, .consumed, .mismatch_count, .extra_count
    );

    always #5 clk = ~clk;

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic word_t take_bits(input int n);
        word_t bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    task automatic generate_program();
        word_t      kind, imm, off;
        reg_addr_t  rd, rj, rk;
        logic [4:0] op5;
        // register file has no reset, so r1 to r7 are set first
        for (int r = 1; r < 8; r++) begin
            imm = take_bits(12);
            imem[r-1] = {OP6_ALU, OP4_ADDI, imm[11:0], 5'd0, reg_addr_t'(r)};
        end
        for (int i = 7; i < PROG_LEN - 1; i++) begin
            kind = take_bits(4);
            rd   = reg_addr_t'(take_bits(3));
            rj   = reg_addr_t'(take_bits(3));
            rk   = reg_addr_t'(take_bits(3));
            off  = 32'd1 + take_bits(2);
            // branch targets stay inside the program
            if (i + int'(off) > PROG_LEN - 1) off = word_t'(PROG_LEN - 1 - i);
            case (kind)
                0: op5 = OP5_ADD;
                1: op5 = OP5_SUB;
                2: op5 = OP5_SLT;
                3: op5 = OP5_SLTU;
                4: op5 = OP5_AND;
                5: op5 = OP5_OR;
                6: op5 = OP5_XOR;
                default: op5 = OP5_NOR;
            endcase
            case (kind)
                8: begin
                    imm = take_bits(12);
                    imem[i] = {OP6_ALU, OP4_ADDI, imm[11:0], rj, rd};
                end
                9: begin
                    imm = take_bits(20);
                    imem[i] = {OP6_LU12I, 1'b0, imm[19:0], rd};
                end
                10, 11: begin
                    imm = take_bits(6);
                    imem[i] = {OP6_MEM, (kind == 10) ? OP4_LDW : OP4_STW,
                               4'h0, imm[5:0], 2'b00, 5'd0, rd};
                end
                12: imem[i] = {OP6_BEQ, off[15:0], rj, rd};
                13: imem[i] = {OP6_BNE, off[15:0], rj, rd};
                14: imem[i] = {OP6_B, off[15:0], off[25:16]};
                15: imem[i] = {OP6_BL, off[15:0], off[25:16]};
                default: imem[i] = {OP6_ALU, 4'h0, OP2_3R, op5, rk, rj, rd};
            endcase
        end
        imem[PROG_LEN-1] = {OP6_B, 26'd0};
    endtask

    function automatic word_t imem_read(input word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        return (idx < PROG_LEN) ? imem[idx] : '0;
    endfunction

    always @(posedge clk) begin
        imem_addr_q <= inst_addr;
        if (data_req.en) begin
            if (data_req.we) dmem[data_req.addr[7:2]] <= data_req.wdata;
            dmem_addr_q <= data_req.addr;
        end
    end

    always @(negedge clk) begin
        inst_rdata <= imem_read(imem_addr_q);
        data_rdata <= dmem[dmem_addr_q[7:2]];
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        inst_rdata  = '0;
        data_rdata  = '0;
        model_start = 1'b0;
        imem_addr_q = '0;
        dmem_addr_q = '0;
        tb_errors   = 0;
        lfsr_state  = 32'h1d06;
        generate_program();
        for (int i = 0; i < 64; i++) begin
            dmem_init[i] = word_t'(i * 4) * 32'h9e3779b1 ^ 32'h5a5a0f0f;
            dmem[i]      = dmem_init[i];
        end
        @(negedge clk);
        model_start = 1'b1;
        repeat (15) @(negedge clk);
        if (inst_addr !== RESET_PC) begin
            $display("FAILED reset fetch address: expected %h, actual %h", RESET_PC, inst_addr);
            tb_errors++;
        end
        reset = 1'b0;

        cycles = 0;
        while ((expected_total == 0 || consumed < expected_total) && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= 5000) begin
            $display("timeout: only %0d of %0d trace records retired", consumed, expected_total);
            tb_errors++;
        end
        // the self loop must stay quiet
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
        end

        $display("errors: mismatch %0d, extra %0d, other %0d (records %0d of %0d)",
                 mismatch_count, extra_count, tb_errors, consumed, expected_total);
        if (mismatch_count + extra_count + tb_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
